//--- verilog/dir_settings.svh
`ifndef DIR_SETTINGS_SVH
`define DIR_SETTINGS_SVH

// directory geometry
`define DIR_SET_NUM 16
`define DIR_WAY_NUM 4
`define DIR_ADDR_W 16
`define DIR_OFFSET_W 4

// queue entries, also the credits upstream holds after reset
`define DIR_REQ_DEPTH 4
// responses the consumer can take after reset
`define DIR_RESP_CREDITS 2

// derived widths
`define DIR_INDEX_W $clog2(`DIR_SET_NUM)
`define DIR_TAG_W (`DIR_ADDR_W - `DIR_INDEX_W - `DIR_OFFSET_W)
`define DIR_WAY_W $clog2(`DIR_WAY_NUM)

`endif

//--- verilog/cache_addr_pkg.sv
`include "dir_settings.svh"

package cache_addr_pkg;

    // address field widths
    localparam int ADDR_W   = `DIR_ADDR_W;
    localparam int OFFSET_W = `DIR_OFFSET_W;
    localparam int INDEX_W  = `DIR_INDEX_W;
    localparam int TAG_W    = `DIR_TAG_W;

    // one request word, seen either as opaque queue payload
    // or split into tag / set index / line offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            // upper bits select the line inside a set
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            // byte within the line, ignored by the directory
            logic [OFFSET_W-1:0] offset;
        } fields;
    } addr_u;

endpackage

//--- verilog/replace_if.sv
`timescale 1ns/1ps
`include "dir_settings.svh"

interface replace_if #(
    parameter int SET_NUM  = `DIR_SET_NUM,
    parameter int WAY_NUM  = `DIR_WAY_NUM,
    parameter int PORT_NUM = 2
);
    localparam int INDEX_W = $clog2(SET_NUM);

    // touch ports, port 0 for hits and port 1 for fills
    logic [PORT_NUM-1:0]              hit_en;
    logic [PORT_NUM-1:0][INDEX_W-1:0] hit_index;
    // one-hot way to mark as most recently used
    logic [PORT_NUM-1:0][WAY_NUM-1:0] hit_way;

    // victim lookup, answer is one-hot and arrives a cycle later
    logic [INDEX_W-1:0] miss_index;
    logic [WAY_NUM-1:0] miss_way;

    modport replace (
        input  hit_en, hit_index, hit_way, miss_index,
        output miss_way
    );

    modport client (
        output hit_en, hit_index, hit_way, miss_index,
        input  miss_way
    );

endinterface

//--- verilog/tag_if.sv
`timescale 1ns/1ps
`include "dir_settings.svh"

interface tag_if;

    // compare group, driven from the queue head in the issue cycle
    logic [`DIR_INDEX_W-1:0] lookup_index;
    logic [`DIR_TAG_W-1:0]   lookup_tag;
    logic                    hit;
    logic [`DIR_WAY_W-1:0]   hit_way_idx;

    // fill group, driven from the fill stage
    logic                    fill_en;
    logic [`DIR_INDEX_W-1:0] fill_index;
    logic [`DIR_WAY_W-1:0]   fill_way_idx;
    logic [`DIR_TAG_W-1:0]   fill_tag;
    // old contents of the line about to be replaced
    logic                    victim_valid;
    logic [`DIR_TAG_W-1:0]   victim_tag;

    modport array (
        input  lookup_index, lookup_tag,
        input  fill_en, fill_index, fill_way_idx, fill_tag,
        output hit, hit_way_idx, victim_valid, victim_tag
    );

    modport ctrl (
        output lookup_index, lookup_tag,
        output fill_en, fill_index, fill_way_idx, fill_tag,
        input  hit, hit_way_idx, victim_valid, victim_tag
    );

endinterface

//--- verilog/plru.sv
`timescale 1ns/1ps
`include "dir_settings.svh"

module plru #(
    parameter int SET_NUM  = `DIR_SET_NUM,
    parameter int WAY_NUM  = `DIR_WAY_NUM,
    parameter int PORT_NUM = 2
) (
    input logic       clk,
    input logic       rst,
    replace_if.replace replace_io
);

    generate
        if (WAY_NUM == 1) begin : g_single
            // nothing to choose from
            assign replace_io.miss_way = 1'b1;
        end else begin : g_tree
            // heap-ordered tree per set, node 0 is the root
            logic [WAY_NUM-2:0] tree_q [SET_NUM];
            logic [WAY_NUM-2:0] tree_rd [PORT_NUM];
            logic [WAY_NUM-2:0] tree_upd [PORT_NUM];
            logic [WAY_NUM-1:0] victim_d;

            for (genvar p = 0; p < PORT_NUM; p++) begin : g_port
                assign tree_rd[p] = tree_q[replace_io.hit_index[p]];

                plru_update #(
                    .WAY_NUM(WAY_NUM)
                ) u_update (
                    .tree_in  (tree_rd[p]),
                    .touch_way(replace_io.hit_way[p]),
                    .tree_out (tree_upd[p])
                );
            end

            // victim comes from the tree as it stands before this edge
            plru_victim #(
                .WAY_NUM(WAY_NUM)
            ) u_victim (
                .tree  (tree_q[replace_io.miss_index]),
                .victim(victim_d)
            );

            always_ff @(posedge clk) begin
                replace_io.miss_way <= victim_d;
            end

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    for (int s = 0; s < SET_NUM; s++) begin
                        tree_q[s] <= '0;
                    end
                end else begin
                    // ports never share a set in the same cycle
                    for (int p = 0; p < PORT_NUM; p++) begin
                        if (replace_io.hit_en[p]) begin
                            tree_q[replace_io.hit_index[p]] <= tree_upd[p];
                        end
                    end
                end
            end
        end
    endgenerate

endmodule

module plru_update #(
    parameter int WAY_NUM = 4
) (
    input  logic [WAY_NUM-2:0] tree_in,
    input  logic [WAY_NUM-1:0] touch_way,
    output logic [WAY_NUM-2:0] tree_out
);
    localparam int WAY_W = $clog2(WAY_NUM);

    always_comb begin
        tree_out = tree_in;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (touch_way[w]) begin
                // walk root to leaf, each node flips to the other half
                for (int lvl = 0; lvl < WAY_W; lvl++) begin
                    tree_out[(1 << lvl) - 1 + (w >> (WAY_W - lvl))] =
                        ~1'(w >> (WAY_W - 1 - lvl));
                end
            end
        end
    end

endmodule

module plru_victim #(
    parameter int WAY_NUM = 4
) (
    input  logic [WAY_NUM-2:0] tree,
    output logic [WAY_NUM-1:0] victim
);
    localparam int WAY_W = $clog2(WAY_NUM);

    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            victim[w] = 1'b1;
            // a leaf wins only if every node on its path points at it
            for (int lvl = 0; lvl < WAY_W; lvl++) begin
                if (tree[(1 << lvl) - 1 + (w >> (WAY_W - lvl))] !=
                    1'(w >> (WAY_W - 1 - lvl))) begin
                    victim[w] = 1'b0;
                end
            end
        end
    end

endmodule

//--- verilog/tag_array.sv
`timescale 1ns/1ps
`include "dir_settings.svh"

module tag_array (
    input logic   clk,
    input logic   rst,
    tag_if.array  tag_io
);
    localparam int SET_NUM = `DIR_SET_NUM;
    localparam int WAY_NUM = `DIR_WAY_NUM;
    localparam int WAY_W   = `DIR_WAY_W;
    localparam int TAG_W   = `DIR_TAG_W;

    logic [TAG_W-1:0]   tags [SET_NUM][WAY_NUM];
    logic [WAY_NUM-1:0] valid [SET_NUM];

    // parallel compare of every way in the looked-up set
    always_comb begin
        tag_io.hit         = 1'b0;
        tag_io.hit_way_idx = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (valid[tag_io.lookup_index][w] &&
                tags[tag_io.lookup_index][w] == tag_io.lookup_tag) begin
                tag_io.hit         = 1'b1;
                tag_io.hit_way_idx = WAY_W'(w);
            end
        end
    end

    // old line contents, read in the same cycle as the fill write
    assign tag_io.victim_valid = valid[tag_io.fill_index][tag_io.fill_way_idx];
    assign tag_io.victim_tag   = tags[tag_io.fill_index][tag_io.fill_way_idx];

    always_ff @(posedge clk) begin
        if (tag_io.fill_en) begin
            tags[tag_io.fill_index][tag_io.fill_way_idx] <= tag_io.fill_tag;
        end
    end

    // lines start invalid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SET_NUM; s++) begin
                valid[s] <= '0;
            end
        end else if (tag_io.fill_en) begin
            valid[tag_io.fill_index][tag_io.fill_way_idx] <= 1'b1;
        end
    end

endmodule

//--- verilog/req_queue.sv
`timescale 1ns/1ps
`include "dir_settings.svh"

module req_queue #(
    parameter int DEPTH = `DIR_REQ_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  logic [`DIR_ADDR_W-1:0] push_addr,
    input  logic                   pop,
    output logic [`DIR_ADDR_W-1:0] head_addr,
    output logic                   head_valid,
    output logic                   credit
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [`DIR_ADDR_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         count;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign full       = (count == (PTR_W + 1)'(DEPTH));
    assign head_valid = (count != '0);
    assign head_addr  = mem[rd_ptr];

    // a full queue means upstream overspent its credits, drop the word
    assign do_push = push && !full;
    assign do_pop  = pop && head_valid;

    // one credit back per entry leaving, same cycle as the dequeue
    assign credit = do_pop;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
        end
    end

endmodule

//--- verilog/lookup_ctrl.sv
`timescale 1ns/1ps
`include "dir_settings.svh"

module lookup_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    head_valid,
    input  cache_addr_pkg::addr_u   head_addr,
    output logic                    pop,
    input  logic                    resp_credit,
    tag_if.ctrl                     tag_io,
    replace_if.client               replace_io,
    output logic                    resp_valid,
    output logic                    resp_hit,
    output logic [`DIR_WAY_W-1:0]   resp_way,
    output logic                    resp_evict_valid,
    output logic [`DIR_TAG_W-1:0]   resp_evict_tag
);
    localparam int WAY_NUM = `DIR_WAY_NUM;
    localparam int WAY_W   = `DIR_WAY_W;
    localparam int CNT_W   = $clog2(`DIR_RESP_CREDITS + 1);

    logic [CNT_W-1:0]        credit_cnt;
    logic                    set_stall;
    logic                    issue;
    logic [WAY_NUM-1:0]      hit_onehot;
    logic [WAY_W-1:0]        victim_idx;
    // fill stage
    logic                    s_valid;
    logic                    s_hit;
    logic [WAY_W-1:0]        s_way;
    logic [`DIR_INDEX_W-1:0] s_index;
    logic [`DIR_TAG_W-1:0]   s_tag;

    // a miss still filling its set would leave the compare stale
    assign set_stall = s_valid && !s_hit && (s_index == head_addr.fields.index);
    assign issue     = head_valid && (credit_cnt != '0) && !set_stall;
    assign pop       = issue;

    // issue stage, compare straight off the queue head
    assign tag_io.lookup_index = head_addr.fields.index;
    assign tag_io.lookup_tag   = head_addr.fields.tag;

    always_comb begin
        hit_onehot = '0;
        hit_onehot[tag_io.hit_way_idx] = 1'b1;
    end

    // port 0 marks the hit way, victim lookup runs for every issue
    assign replace_io.hit_en[0]    = issue && tag_io.hit;
    assign replace_io.hit_index[0] = head_addr.fields.index;
    assign replace_io.hit_way[0]   = hit_onehot;
    assign replace_io.miss_index   = head_addr.fields.index;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_valid <= 1'b0;
        end else begin
            s_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            s_hit   <= tag_io.hit;
            s_way   <= tag_io.hit_way_idx;
            s_index <= head_addr.fields.index;
            s_tag   <= head_addr.fields.tag;
        end
    end

    // registered one-hot victim to way index
    always_comb begin
        victim_idx = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (replace_io.miss_way[w]) begin
                victim_idx = WAY_W'(w);
            end
        end
    end

    // fill stage, install the tag and touch the filled way on port 1
    assign tag_io.fill_en          = s_valid && !s_hit;
    assign tag_io.fill_index       = s_index;
    assign tag_io.fill_way_idx     = victim_idx;
    assign tag_io.fill_tag         = s_tag;
    assign replace_io.hit_en[1]    = s_valid && !s_hit;
    assign replace_io.hit_index[1] = s_index;
    assign replace_io.hit_way[1]   = replace_io.miss_way;

    // response one cycle after issue
    assign resp_valid       = s_valid;
    assign resp_hit         = s_valid && s_hit;
    assign resp_way         = s_hit ? s_way : victim_idx;
    assign resp_evict_valid = s_valid && !s_hit && tag_io.victim_valid;
    assign resp_evict_tag   = tag_io.victim_tag;

    // spend a credit per issue, get one back per consumer pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_cnt <= CNT_W'(`DIR_RESP_CREDITS);
        end else begin
            credit_cnt <= credit_cnt + CNT_W'(resp_credit) - CNT_W'(issue);
        end
    end

endmodule

//--- verilog/cache_dir.sv
`timescale 1ns/1ps

module cache_dir (
    input  logic                             clk,
    input  logic                             rst,
    // request channel, one request per upstream credit
    input  logic                             req_valid,
    input  cache_addr_pkg::addr_u            req_addr,
    output logic                             req_credit,
    // response channel, in request order
    output logic                             resp_valid,
    output logic                             resp_hit,
    output logic [1:0]                       resp_way,
    output logic                             resp_evict_valid,
    output logic [cache_addr_pkg::TAG_W-1:0] resp_evict_tag,
    input  logic                             resp_credit
);

    cache_addr_pkg::addr_u head_addr;
    logic                  head_valid;
    logic                  pop;

    replace_if replace_bus ();
    tag_if     tag_bus ();

    // queue only sees the raw word
    req_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (req_valid),
        .push_addr (req_addr.raw),
        .pop       (pop),
        .head_addr (head_addr.raw),
        .head_valid(head_valid),
        .credit    (req_credit)
    );

    lookup_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .head_valid      (head_valid),
        .head_addr       (head_addr),
        .pop             (pop),
        .resp_credit     (resp_credit),
        .tag_io          (tag_bus.ctrl),
        .replace_io      (replace_bus.client),
        .resp_valid      (resp_valid),
        .resp_hit        (resp_hit),
        .resp_way        (resp_way),
        .resp_evict_valid(resp_evict_valid),
        .resp_evict_tag  (resp_evict_tag)
    );

    tag_array u_tags (
        .clk   (clk),
        .rst   (rst),
        .tag_io(tag_bus.array)
    );

    plru u_plru (
        .clk       (clk),
        .rst       (rst),
        .replace_io(replace_bus.replace)
    );

endmodule

//--- test/cache_dir_checker.sv
`timescale 1ns/1ps
`include "dir_settings.svh"

module cache_dir_checker (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic req_credit,
    input logic resp_valid,
    input logic resp_hit,
    input logic resp_evict_valid,
    input logic resp_credit
);

    // queue occupancy as seen from the request port
    int queue_cnt;
    // responses sent and not yet paid back by the consumer
    int outstanding;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            queue_cnt   <= 0;
            outstanding <= 0;
        end else begin
            queue_cnt   <= queue_cnt + int'(req_valid) - int'(req_credit);
            outstanding <= outstanding + int'(resp_valid) - int'(resp_credit);
        end
    end

    // both outside channels stay quiet while reset is held
    quiet_in_reset: assert property (@(posedge clk) rst |-> (!resp_valid && !req_credit))
        else $error("response or request credit active during reset");

    // a hit never evicts anything
    hit_no_evict: assert property (@(posedge clk) disable iff (rst)
        !(resp_hit && resp_evict_valid))
        else $error("hit response also flags an eviction");

    resp_credit_bound: assert property (@(posedge clk) disable iff (rst)
        outstanding <= `DIR_RESP_CREDITS)
        else $error("more responses outstanding than consumer credits");

    // upstream may only push into a free slot
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> (queue_cnt < `DIR_REQ_DEPTH))
        else $error("request pushed into a full queue");

endmodule

bind cache_dir cache_dir_checker u_checker (
    .clk             (clk),
    .rst             (rst),
    .req_valid       (req_valid),
    .req_credit      (req_credit),
    .resp_valid      (resp_valid),
    .resp_hit        (resp_hit),
    .resp_evict_valid(resp_evict_valid),
    .resp_credit     (resp_credit)
);

//--- test/cache_dir_tb.sv
`timescale 1ns/1ps
`include "dir_settings.svh"

module cache_dir_tb;

    localparam int NUM_REQ        = 500;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 12 + 200;
    // consumer withholds all response credits over this window
    localparam int HOLD_START     = 300;
    localparam int HOLD_LEN       = 40;

    typedef struct packed {
        logic       first;
        logic       hit;
        logic [1:0] way;
        logic       evict_valid;
        logic [7:0] evict_tag;
    } resp_t;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic [15:0] req_addr;
    logic        req_credit;
    logic        resp_valid;
    logic        resp_hit;
    logic [1:0]  resp_way;
    logic        resp_evict_valid;
    logic [7:0]  resp_evict_tag;
    logic        resp_credit;

    // reference directory state per set and way
    // tree bit 0 is the root
    // bit 1 covers ways 0/1 and bit 2 covers ways 2/3
    logic [7:0] m_tag   [`DIR_SET_NUM][`DIR_WAY_NUM];
    logic       m_valid [`DIR_SET_NUM][`DIR_WAY_NUM];
    logic [2:0] m_tree  [`DIR_SET_NUM];
    logic       m_seen  [`DIR_SET_NUM];

    // small address pool so hits, misses and evictions all show up
    logic [7:0] tag_pool [6];
    logic [3:0] set_pool [3];

    resp_t  expected_q [$];
    int     credit_due [$];
    integer seed;
    int     cycle;
    int     sent;
    int     resp_count;
    int     credit_pulses;
    int     req_credits;
    int     hold_resps;
    int     hold_pops;

    cache_dir dut (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (req_valid),
        .req_addr        (req_addr),
        .req_credit      (req_credit),
        .resp_valid      (resp_valid),
        .resp_hit        (resp_hit),
        .resp_way        (resp_way),
        .resp_evict_valid(resp_evict_valid),
        .resp_evict_tag  (resp_evict_tag),
        .resp_credit     (resp_credit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Error: %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // follow the node bits down to a leaf
    function automatic logic [1:0] victim_of(input logic [2:0] tree);
        if (tree[0] == 1'b0) begin
            return tree[1] ? 2'd1 : 2'd0;
        end
        return tree[2] ? 2'd3 : 2'd2;
    endfunction

    // nodes on the touched way's path now point at the other side
    function automatic logic [2:0] touch(input logic [2:0] tree, input logic [1:0] way);
        logic [2:0] t;
        t = tree;
        t[0] = (way < 2'd2);
        if (way < 2'd2) begin
            t[1] = (way == 2'd0);
        end else begin
            t[2] = (way == 2'd2);
        end
        return t;
    endfunction

    // apply one access in request order and return the expected response
    function automatic resp_t model_access(input logic [7:0] tag, input logic [3:0] set);
        resp_t r;
        r = '0;
        r.first = !m_seen[set];
        m_seen[set] = 1'b1;
        for (int w = 0; w < `DIR_WAY_NUM; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                r.hit = 1'b1;
                r.way = 2'(w);
            end
        end
        if (!r.hit) begin
            r.way = victim_of(m_tree[set]);
            r.evict_valid = m_valid[set][r.way];
            r.evict_tag = m_tag[set][r.way];
            m_valid[set][r.way] = 1'b1;
            m_tag[set][r.way] = tag;
        end
        m_tree[set] = touch(m_tree[set], r.way);
        return r;
    endfunction

    task automatic check_response();
        resp_t e;
        if (expected_q.size() == 0) begin
            abort_run("a response came back with no request outstanding");
        end
        e = expected_q.pop_front();
        check_value("resp_hit", e.hit, resp_hit);
        check_value("resp_way", e.way, resp_way);
        check_value("resp_evict_valid", e.evict_valid, resp_evict_valid);
        if (e.evict_valid) begin
            check_value("resp_evict_tag", e.evict_tag, resp_evict_tag);
        end
        // cold set always fills way 0 without evicting
        if (e.first) begin
            check_value("first_access_way", 0, resp_way);
            check_value("first_access_evict", 0, resp_evict_valid);
        end
    endtask

    initial begin
        logic [7:0] tag;
        logic [3:0] set;
        logic [3:0] offset;
        logic       credit_seen;
        logic       in_hold;
        seed = 32'h49a;
        tag_pool = '{8'h12, 8'h34, 8'h56, 8'h78, 8'h9a, 8'hbc};
        set_pool = '{4'h3, 4'h7, 4'hc};
        for (int s = 0; s < `DIR_SET_NUM; s++) begin
            m_tree[s] = '0;
            m_seen[s] = 1'b0;
            for (int w = 0; w < `DIR_WAY_NUM; w++) begin
                m_tag[s][w] = '0;
                m_valid[s][w] = 1'b0;
            end
        end
        cycle = 0;
        sent = 0;
        resp_count = 0;
        credit_pulses = 0;
        req_credits = `DIR_REQ_DEPTH;
        hold_resps = 0;
        hold_pops = 0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        resp_credit = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (resp_count < NUM_REQ) begin
            @(negedge clk);
            cycle++;
            if (cycle >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("timeout after %0d cycles, only %0d of %0d responses seen",
                                    cycle, resp_count, NUM_REQ));
            end
            credit_seen = req_credit;
            in_hold = (cycle >= HOLD_START) && (cycle < HOLD_START + HOLD_LEN);
            // nothing comes out before the first request goes in
            if (sent == 0) begin
                check_value("idle_resp_valid", 0, resp_valid);
                check_value("idle_req_credit", 0, req_credit);
            end
            if (req_credit) begin
                credit_pulses++;
            end
            if (resp_valid) begin
                check_response();
                resp_count++;
                credit_due.push_back(cycle + int'($unsigned($random(seed)) % 4));
            end
            if (in_hold) begin
                hold_resps += resp_valid;
                hold_pops += req_credit;
            end
            // by the end of the window the queue has filled and upstream ran dry
            if (cycle == HOLD_START + HOLD_LEN) begin
                check_value("hold_resps_bounded", 1, hold_resps <= `DIR_RESP_CREDITS);
                check_value("hold_pops_bounded", 1, hold_pops <= `DIR_RESP_CREDITS);
                check_value("hold_req_credits", 0, req_credits);
            end

            // pay back at most one response credit per cycle
            resp_credit = 1'b0;
            if (!in_hold && credit_due.size() != 0 && credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                resp_credit = 1'b1;
            end

            req_valid = 1'b0;
            if (req_credits > 0 && sent < NUM_REQ && ($random(seed) & 3) != 0) begin
                tag = tag_pool[$unsigned($random(seed)) % 6];
                set = set_pool[$unsigned($random(seed)) % 3];
                offset = 4'($random(seed));
                expected_q.push_back(model_access(tag, set));
                req_addr = {tag, set, offset};
                req_valid = 1'b1;
                req_credits--;
                sent++;
            end
            // the slot frees at the coming edge and the credit is usable from the next cycle
            if (credit_seen) begin
                req_credits++;
            end
        end

        // drained pipeline stays silent
        repeat (5) begin
            @(negedge clk);
            resp_credit = 1'b0;
            check_value("drain_resp_valid", 0, resp_valid);
            check_value("drain_req_credit", 0, req_credit);
        end
        check_value("credit_pulses", NUM_REQ, credit_pulses);
        $display("TEST OK");
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/cache_addr_pkg.sv
verilog/replace_if.sv
verilog/tag_if.sv
verilog/plru.sv
verilog/tag_array.sv
verilog/req_queue.sv
verilog/lookup_ctrl.sv
verilog/cache_dir.sv
test/cache_dir_checker.sv
test/cache_dir_tb.sv
